// ==== decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                clk,
    input  logic                rst,
    stage_if.dst                in,
    stage_if.src                out,
    input  logic                wb_en,
    input  pipe_pkg::reg_addr_t wb_addr,
    input  pipe_pkg::word_t     wb_data,
    stage_if.mon                e2m_peek
);

    pipe_pkg::word_t     rf [pipe_pkg::NUM_REGS];
    pipe_pkg::op_t       op;
    pipe_pkg::reg_addr_t rd;
    pipe_pkg::reg_addr_t rs1;
    pipe_pkg::reg_addr_t src_b;
    pipe_pkg::word_t     imm;
    pipe_pkg::word_t     a_val;
    pipe_pkg::word_t     b_val;
    logic                use_a;
    logic                use_b;
    logic                use_imm;
    logic                writes;
    logic                stall;

    function automatic logic pending(input pipe_pkg::reg_addr_t addr);
        logic in_ex;
        logic in_mem;
        in_ex  = out.valid && out.payload.wr && (out.payload.rd == addr);
        in_mem = e2m_peek.valid && e2m_peek.payload.wr && (e2m_peek.payload.rd == addr);
        return (addr != '0) && (in_ex || in_mem);
    endfunction

    function automatic pipe_pkg::word_t read_reg(input pipe_pkg::reg_addr_t addr);
        pipe_pkg::word_t val;
        val = rf[addr];
        // Same-cycle write-back is visible to the read port
        if (wb_en && wb_addr == addr)
            val = wb_data;
        if (addr == '0)
            val = '0;
        return val;
    endfunction

    always_comb begin
        op    = pipe_pkg::op_t'(in.payload.instr[pipe_pkg::OP_MSB:pipe_pkg::OP_LSB]);
        rd    = in.payload.instr[pipe_pkg::RD_MSB:pipe_pkg::RD_LSB];
        rs1   = in.payload.instr[pipe_pkg::RS1_MSB:pipe_pkg::RS1_LSB];
        // SW takes its store data from the rd field
        src_b = (op == pipe_pkg::OP_SW) ? rd
                                        : in.payload.instr[pipe_pkg::RS2_MSB:pipe_pkg::RS2_LSB];
        imm   = {{(16 - pipe_pkg::IMM_MSB - 1){in.payload.instr[pipe_pkg::IMM_MSB]}},
                 in.payload.instr[pipe_pkg::IMM_MSB:pipe_pkg::IMM_LSB]};
        use_imm = op inside {pipe_pkg::OP_ADDI, pipe_pkg::OP_LW, pipe_pkg::OP_SW};
        use_a   = use_imm || (op inside {pipe_pkg::OP_ADD, pipe_pkg::OP_SUB,
                                         pipe_pkg::OP_AND, pipe_pkg::OP_XOR});
        use_b   = op inside {pipe_pkg::OP_ADD, pipe_pkg::OP_SUB, pipe_pkg::OP_AND,
                             pipe_pkg::OP_XOR, pipe_pkg::OP_SW};
        writes  = (rd != '0) && (op inside {pipe_pkg::OP_ADD, pipe_pkg::OP_SUB,
                                            pipe_pkg::OP_AND, pipe_pkg::OP_XOR,
                                            pipe_pkg::OP_ADDI, pipe_pkg::OP_LW});
        stall   = in.valid && ((use_a && pending(rs1)) || (use_b && pending(src_b)));
        a_val   = read_reg(rs1);
        b_val   = read_reg(src_b);
    end

    assign in.hold = stall || out.hold;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < pipe_pkg::NUM_REGS; i++) begin
                rf[i] <= '0;
            end
        end else if (wb_en && wb_addr != '0) begin
            rf[wb_addr] <= wb_data;
        end
    end

    // A stall sends a bubble toward execute
    always_ff @(posedge clk) begin
        if (rst)
            out.valid <= 1'b0;
        else if (!out.hold)
            out.valid <= in.valid && !stall;
    end

    always_ff @(posedge clk) begin
        if (!out.hold && in.valid && !stall) begin
            out.tag     <= in.tag;
            out.payload <= '{op: op, rd: rd, wr: writes, a: a_val,
                             b: use_imm ? imm : b_val, sd: b_val};
        end
    end

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic clk,
    input  logic rst,
    stage_if.dst in,
    stage_if.src out
);

    pipe_pkg::word_t result;

    always_comb begin
        case (in.payload.op)
            pipe_pkg::OP_NOP: result = '0;
            pipe_pkg::OP_SUB: result = in.payload.a - in.payload.b;
            pipe_pkg::OP_AND: result = in.payload.a & in.payload.b;
            pipe_pkg::OP_XOR: result = in.payload.a ^ in.payload.b;
            // ADD, ADDI and the LW/SW address share the adder
            default:          result = in.payload.a + in.payload.b;
        endcase
    end

    // No hold of its own, only what memory asks for
    assign in.hold = out.hold;

    always_ff @(posedge clk) begin
        if (rst)
            out.valid <= 1'b0;
        else if (!out.hold)
            out.valid <= in.valid;
    end

    always_ff @(posedge clk) begin
        if (!out.hold && in.valid) begin
            out.tag     <= in.tag;
            out.payload <= '{op: in.payload.op, rd: in.payload.rd, wr: in.payload.wr,
                             res: result, sd: in.payload.sd};
        end
    end

endmodule

// ==== fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    input  pipe_pkg::word_t in_word,
    output logic            in_stall,
    output logic            accept,
    output pipe_pkg::tag_t  next_tag,
    stage_if.src            out
);

    pipe_pkg::word_t pc;

    // Source is stalled exactly when decode holds us
    assign in_stall = out.hold;
    assign accept   = in_valid && !out.hold;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= '0;
            next_tag  <= '0;
            out.valid <= 1'b0;
        end else if (!out.hold) begin
            out.valid <= in_valid;
            if (in_valid) begin
                pc       <= pc + 16'd1;
                next_tag <= next_tag + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out.tag     <= next_tag;
            out.payload <= '{pc: pc, instr: in_word};
        end
    end

endmodule

// ==== list.f ====
pipe_pkg.sv
stage_if.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
pipeline_tracker.sv
pipe_top.sv
tb_clock.sv
pipe_props.sv
pipe_tb.sv

// ==== memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage (
    input  logic                clk,
    input  logic                rst,
    stage_if.dst                in,
    output logic                wb_en,
    output pipe_pkg::reg_addr_t wb_addr,
    output pipe_pkg::word_t     wb_data,
    output logic                ret_valid,
    output pipe_pkg::tag_t      ret_tag,
    output pipe_pkg::word_t     ret_result
);

    pipe_pkg::word_t              dmem [pipe_pkg::DMEM_WORDS];
    logic [pipe_pkg::DMEM_AW-1:0] addr;
    pipe_pkg::word_t              result;

    // Last stage, nothing downstream can back up
    assign in.hold = 1'b0;

    assign addr = in.payload.res[pipe_pkg::DMEM_AW-1:0];

    always_comb begin
        case (in.payload.op)
            pipe_pkg::OP_LW: result = dmem[addr];
            pipe_pkg::OP_SW: result = in.payload.sd;
            default:         result = in.payload.res;
        endcase
    end

    // Register write-back straight from the input register
    assign wb_en   = in.valid && in.payload.wr;
    assign wb_addr = in.payload.rd;
    assign wb_data = result;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < pipe_pkg::DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (in.valid && in.payload.op == pipe_pkg::OP_SW) begin
            dmem[addr] <= in.payload.sd;
        end
    end

    // One strobe per completed instruction, bubbles excluded
    always_ff @(posedge clk) begin
        if (rst)
            ret_valid <= 1'b0;
        else
            ret_valid <= in.valid;
    end

    always_ff @(posedge clk) begin
        if (in.valid) begin
            ret_tag    <= in.tag;
            ret_result <= result;
        end
    end

endmodule

// ==== pipe_pkg.sv ====
package pipe_pkg;

    // Operation codes held in instruction bits 15..12
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_XOR  = 4'h4,
        OP_ADDI = 4'h5,
        OP_LW   = 4'h6,
        OP_SW   = 4'h7
    } op_t;

    typedef logic [2:0]  reg_addr_t;
    typedef logic [15:0] word_t;

    // Instruction field positions
    localparam int OP_MSB  = 15;
    localparam int OP_LSB  = 12;
    localparam int RD_MSB  = 11;
    localparam int RD_LSB  = 9;
    localparam int RS1_MSB = 8;
    localparam int RS1_LSB = 6;
    localparam int RS2_MSB = 5;
    localparam int RS2_LSB = 3;
    localparam int IMM_MSB = 5;
    localparam int IMM_LSB = 0;

    localparam int TAG_W      = 3;
    localparam int TAG_DEPTH  = 2 ** TAG_W;
    localparam int CYC_W      = 16;
    localparam int NUM_REGS   = 8;
    localparam int DMEM_WORDS = 16;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [CYC_W-1:0] cyc_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } fetch_pl_t;

    // Operand b already holds the sign-extended immediate where one is used
    typedef struct packed {
        op_t       op;
        reg_addr_t rd;
        logic      wr;
        word_t     a;
        word_t     b;
        word_t     sd;
    } exec_pl_t;

    typedef struct packed {
        op_t       op;
        reg_addr_t rd;
        logic      wr;
        word_t     res;
        word_t     sd;
    } mem_pl_t;

    typedef struct packed {
        tag_t  tag;
        word_t pc;
        cyc_t  fetch_cycle;
        cyc_t  stall_cycles;
        cyc_t  retire_cycle;
        word_t result;
    } retire_rec_t;

endpackage

// ==== pipe_props.sv ====
`timescale 1ns/1ps

module pipe_props (
    input logic           clk,
    input logic           rst,
    input logic           in_stall,
    input pipe_pkg::tag_t next_tag,
    input logic           retire_valid,
    input pipe_pkg::cyc_t retire_fetch_cycle,
    input pipe_pkg::cyc_t retire_stall_cycles,
    input pipe_pkg::cyc_t retire_cycle
);

    // Reset clears the retire strobe by the following edge
    a_quiet_in_reset: assert property (@(posedge clk) rst |=> !retire_valid)
        else $error("retire_valid high during reset");

    // A stalled edge must not take a word, so the tag counter stays put
    a_no_accept_in_stall: assert property (@(posedge clk) disable iff (rst)
        in_stall |=> next_tag == $past(next_tag))
        else $error("word accepted while in_stall is high");

    a_min_latency: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> retire_cycle >= retire_fetch_cycle + 16'd4)
        else $error("retire earlier than four cycles after fetch");

    // Every cycle beyond the base latency is a decode stall
    a_stall_count: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> retire_stall_cycles == retire_cycle - retire_fetch_cycle - 16'd4)
        else $error("stall count does not match the retire latency");

endmodule

bind pipe_top pipe_props u_props (
    .clk                 (clk),
    .rst                 (rst),
    .in_stall            (in_stall),
    .next_tag            (next_tag),
    .retire_valid        (retire_valid),
    .retire_fetch_cycle  (retire_fetch_cycle),
    .retire_stall_cycles (retire_stall_cycles),
    .retire_cycle        (retire_cycle)
);

// ==== pipe_tb.sv ====
`timescale 1ns/1ps

module pipe_tb;

    localparam int RANDOM_COUNT = 32;
    // Directed blocks hold 11, 18, 8 and 6 instructions
    localparam int NUM_INSTR    = 11 + 18 + 8 + 6 + RANDOM_COUNT;
    localparam int TIMEOUT      = NUM_INSTR * 8 + 200;
    localparam pipe_pkg::word_t NOP_WORD = 16'h0000;

    logic            clk;
    logic            rst;
    logic            in_valid;
    pipe_pkg::word_t in_word;
    logic            in_stall;
    logic            retire_valid;
    pipe_pkg::tag_t  retire_tag;
    pipe_pkg::word_t retire_pc;
    pipe_pkg::cyc_t  retire_fetch_cycle;
    pipe_pkg::cyc_t  retire_stall_cycles;
    pipe_pkg::cyc_t  retire_cycle;
    pipe_pkg::word_t retire_result;

    // Reference state, updated in program order at acceptance
    pipe_pkg::word_t       model_rf  [pipe_pkg::NUM_REGS];
    pipe_pkg::word_t       model_mem [pipe_pkg::DMEM_WORDS];
    pipe_pkg::cyc_t        ready_at  [pipe_pkg::NUM_REGS];
    pipe_pkg::retire_rec_t expect_q  [$];
    pipe_pkg::word_t       next_pc;
    pipe_pkg::cyc_t        cyc;
    int                    timer;

    tb_clock #(.PERIOD_NS(8)) u_clock (.clk(clk));

    pipe_top u_pipe_top (
        .clk                 (clk),
        .rst                 (rst),
        .in_valid            (in_valid),
        .in_word             (in_word),
        .in_stall            (in_stall),
        .retire_valid        (retire_valid),
        .retire_tag          (retire_tag),
        .retire_pc           (retire_pc),
        .retire_fetch_cycle  (retire_fetch_cycle),
        .retire_stall_cycles (retire_stall_cycles),
        .retire_cycle        (retire_cycle),
        .retire_result       (retire_result)
    );

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input pipe_pkg::word_t act,
                              input pipe_pkg::word_t want);
        if (act !== want)
            fail_now($sformatf("[FAIL] %s: got %h, expected %h", name, act, want));
    endtask

    task automatic check_cyc(input string name, input pipe_pkg::cyc_t act,
                             input pipe_pkg::cyc_t want);
        if (act !== want)
            fail_now($sformatf("[FAIL] %s: got %h, expected %h", name, act, want));
    endtask

    task automatic check_tag(input string name, input pipe_pkg::tag_t act,
                             input pipe_pkg::tag_t want);
        if (act !== want)
            fail_now($sformatf("[FAIL] %s: got %h, expected %h", name, act, want));
    endtask

    function automatic pipe_pkg::word_t r_type(input pipe_pkg::op_t op, input int rd,
                                               input int rs1, input int rs2);
        return {op, 3'(rd), 3'(rs1), 3'(rs2), 3'b000};
    endfunction

    function automatic pipe_pkg::word_t i_type(input pipe_pkg::op_t op, input int rd,
                                               input int rs1, input int imm);
        return {op, 3'(rd), 3'(rs1), 6'(imm)};
    endfunction

    // A source can leave decode three edges after its producer did
    function automatic pipe_pkg::cyc_t ready_after(input pipe_pkg::reg_addr_t r,
                                                   input pipe_pkg::cyc_t t);
        return (ready_at[r] > t) ? ready_at[r] : t;
    endfunction

    task automatic model_step(input pipe_pkg::word_t w);
        pipe_pkg::op_t         op;
        pipe_pkg::reg_addr_t   rd;
        pipe_pkg::reg_addr_t   rs1;
        pipe_pkg::reg_addr_t   rs2;
        pipe_pkg::word_t       imm;
        pipe_pkg::word_t       res;
        pipe_pkg::cyc_t        leave;
        pipe_pkg::retire_rec_t rec;
        logic                  alu;
        op    = pipe_pkg::op_t'(w[15:12]);
        rd    = w[11:9];
        rs1   = w[8:6];
        rs2   = w[5:3];
        imm   = {{10{w[5]}}, w[5:0]};
        alu   = op inside {pipe_pkg::OP_ADD, pipe_pkg::OP_SUB, pipe_pkg::OP_AND,
                           pipe_pkg::OP_XOR};
        // Earliest exit from decode is the edge after acceptance
        leave = cyc + 16'd1;
        if (op != pipe_pkg::OP_NOP)
            leave = ready_after(rs1, leave);
        if (alu)
            leave = ready_after(rs2, leave);
        if (op == pipe_pkg::OP_SW)
            leave = ready_after(rd, leave);
        case (op)
            pipe_pkg::OP_ADD:  res = model_rf[rs1] + model_rf[rs2];
            pipe_pkg::OP_SUB:  res = model_rf[rs1] - model_rf[rs2];
            pipe_pkg::OP_AND:  res = model_rf[rs1] & model_rf[rs2];
            pipe_pkg::OP_XOR:  res = model_rf[rs1] ^ model_rf[rs2];
            pipe_pkg::OP_ADDI: res = model_rf[rs1] + imm;
            pipe_pkg::OP_LW:   res = model_mem[4'(model_rf[rs1] + imm)];
            pipe_pkg::OP_SW: begin
                res = model_rf[rd];
                model_mem[4'(model_rf[rs1] + imm)] = res;
            end
            default:           res = '0;
        endcase
        if ((alu || op inside {pipe_pkg::OP_ADDI, pipe_pkg::OP_LW}) && rd != '0) begin
            model_rf[rd] = res;
            ready_at[rd] = leave + 16'd3;
        end
        rec.tag          = next_pc[pipe_pkg::TAG_W-1:0];
        rec.pc           = next_pc;
        rec.fetch_cycle  = cyc;
        rec.stall_cycles = leave - cyc - 16'd1;
        rec.retire_cycle = leave + 16'd3;
        rec.result       = res;
        expect_q.push_back(rec);
        next_pc = next_pc + 16'd1;
    endtask

    // in_stall is settled at the falling edge and governs the next rising edge
    task automatic issue(input pipe_pkg::word_t w);
        in_valid = 1'b1;
        in_word  = w;
        while (in_stall)
            @(negedge clk);
        model_step(w);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic issue_nops(input int n);
        repeat (n) issue(NOP_WORD);
    endtask

    task automatic check_retire();
        pipe_pkg::retire_rec_t want;
        if (expect_q.size() == 0) begin
            fail_now("Retire record seen with no instruction outstanding");
        end else begin
            want = expect_q.pop_front();
            check_tag("retire_tag", retire_tag, want.tag);
            check_word("retire_pc", retire_pc, want.pc);
            check_word("retire_result", retire_result, want.result);
            check_cyc("retire_fetch_cycle", retire_fetch_cycle, want.fetch_cycle);
            check_cyc("retire_stall_cycles", retire_stall_cycles, want.stall_cycles);
            check_cyc("latency", retire_cycle - retire_fetch_cycle,
                      want.retire_cycle - want.fetch_cycle);
        end
    endtask

    always @(posedge clk) begin
        if (rst)
            cyc <= '0;
        else
            cyc <= cyc + 16'd1;
        timer <= timer + 1;
        if (timer >= TIMEOUT)
            fail_now("Timeout: not all instructions retired in time");
    end

    always @(negedge clk) begin
        if (!rst && retire_valid)
            check_retire();
    end

    task automatic test_reset_state();
        if (retire_valid !== 1'b0 || in_stall !== 1'b0)
            fail_now("retire_valid or in_stall not low after reset");
    endtask

    task automatic test_alu_independent();
        issue(i_type(pipe_pkg::OP_ADDI, 1, 0, 5));
        issue(i_type(pipe_pkg::OP_ADDI, 2, 0, -3));
        issue(i_type(pipe_pkg::OP_ADDI, 3, 0, 22));
        issue(i_type(pipe_pkg::OP_ADDI, 4, 0, 9));
        issue(i_type(pipe_pkg::OP_ADDI, 7, 0, -32));
        issue_nops(2);
        issue(r_type(pipe_pkg::OP_ADD, 5, 1, 2));
        issue(r_type(pipe_pkg::OP_SUB, 6, 3, 4));
        issue(r_type(pipe_pkg::OP_XOR, 3, 4, 7));
        issue(r_type(pipe_pkg::OP_AND, 4, 1, 7));
    endtask

    task automatic test_dependency_distance();
        issue(i_type(pipe_pkg::OP_ADDI, 1, 0, 12));
        issue(r_type(pipe_pkg::OP_ADD, 2, 1, 1));
        issue_nops(3);
        issue(i_type(pipe_pkg::OP_ADDI, 3, 0, 7));
        issue_nops(1);
        issue(r_type(pipe_pkg::OP_SUB, 4, 3, 2));
        issue_nops(3);
        issue(i_type(pipe_pkg::OP_ADDI, 5, 0, -1));
        issue_nops(2);
        issue(r_type(pipe_pkg::OP_XOR, 6, 5, 4));
        // Back-to-back chain on one register
        issue(i_type(pipe_pkg::OP_ADDI, 7, 0, 3));
        issue(r_type(pipe_pkg::OP_ADD, 7, 7, 7));
        issue(r_type(pipe_pkg::OP_ADD, 7, 7, 7));
    endtask

    task automatic test_load_store();
        issue(i_type(pipe_pkg::OP_ADDI, 1, 0, 25));
        issue(i_type(pipe_pkg::OP_ADDI, 2, 0, 4));
        issue(i_type(pipe_pkg::OP_SW, 1, 2, 3));
        issue(i_type(pipe_pkg::OP_LW, 3, 2, 3));
        issue(i_type(pipe_pkg::OP_LW, 4, 0, 9));
        issue(r_type(pipe_pkg::OP_ADD, 5, 3, 3));
        issue(i_type(pipe_pkg::OP_SW, 5, 2, -2));
        issue(i_type(pipe_pkg::OP_LW, 6, 0, 2));
    endtask

    task automatic test_random_gaps();
        pipe_pkg::word_t w;
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            w     = 16'($urandom);
            // Keep the opcode inside the eight defined operations
            w[15] = 1'b0;
            repeat ($urandom % 4) @(negedge clk);
            issue(w);
        end
    endtask

    task automatic test_r0_writes();
        issue(i_type(pipe_pkg::OP_ADDI, 0, 0, 7));
        issue(r_type(pipe_pkg::OP_ADD, 1, 0, 0));
        issue(i_type(pipe_pkg::OP_LW, 0, 0, 7));
        issue(i_type(pipe_pkg::OP_ADDI, 3, 0, 1));
        issue(i_type(pipe_pkg::OP_SW, 0, 0, 5));
        issue(i_type(pipe_pkg::OP_LW, 4, 0, 5));
    endtask

    initial begin
        void'($urandom(94791));
        rst      = 1'b1;
        in_valid = 1'b0;
        in_word  = '0;
        next_pc  = '0;
        timer    = 0;
        for (int i = 0; i < pipe_pkg::NUM_REGS; i++) begin
            model_rf[i] = '0;
            ready_at[i] = '0;
        end
        for (int i = 0; i < pipe_pkg::DMEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_reset_state();
        test_alu_independent();
        test_dependency_distance();
        test_load_store();
        test_random_gaps();
        test_r0_writes();

        while (expect_q.size() != 0)
            @(negedge clk);
        // Watch a little longer for a stray retire record
        repeat (10) @(negedge clk);
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== pipe_top.sv ====
`timescale 1ns/1ps

module pipe_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    input  pipe_pkg::word_t in_word,
    output logic            in_stall,
    output logic            retire_valid,
    output pipe_pkg::tag_t  retire_tag,
    output pipe_pkg::word_t retire_pc,
    output pipe_pkg::cyc_t  retire_fetch_cycle,
    output pipe_pkg::cyc_t  retire_stall_cycles,
    output pipe_pkg::cyc_t  retire_cycle,
    output pipe_pkg::word_t retire_result
);

    logic                  accept;
    pipe_pkg::tag_t        next_tag;
    logic                  wb_en;
    pipe_pkg::reg_addr_t   wb_addr;
    pipe_pkg::word_t       wb_data;
    logic                  ret_valid;
    pipe_pkg::tag_t        ret_tag;
    pipe_pkg::word_t       ret_result;
    pipe_pkg::retire_rec_t retire_rec;

    stage_if #(.payload_t(pipe_pkg::fetch_pl_t)) f2d ();
    stage_if #(.payload_t(pipe_pkg::exec_pl_t))  d2e ();
    stage_if #(.payload_t(pipe_pkg::mem_pl_t))   e2m ();

    fetch_stage u_fetch (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_word  (in_word),
        .in_stall (in_stall),
        .accept   (accept),
        .next_tag (next_tag),
        .out      (f2d.src)
    );

    decode_stage u_decode (
        .clk      (clk),
        .rst      (rst),
        .in       (f2d.dst),
        .out      (d2e.src),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data),
        .e2m_peek (e2m.mon)
    );

    execute_stage u_execute (
        .clk (clk),
        .rst (rst),
        .in  (d2e.dst),
        .out (e2m.src)
    );

    memory_stage u_memory (
        .clk        (clk),
        .rst        (rst),
        .in         (e2m.dst),
        .wb_en      (wb_en),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .ret_valid  (ret_valid),
        .ret_tag    (ret_tag),
        .ret_result (ret_result)
    );

    pipeline_tracker u_tracker (
        .clk          (clk),
        .rst          (rst),
        .fetch_mon    (f2d.mon),
        .in_accept    (accept),
        .in_tag       (next_tag),
        .ret_valid    (ret_valid),
        .ret_tag      (ret_tag),
        .ret_result   (ret_result),
        .retire_valid (retire_valid),
        .retire_rec   (retire_rec)
    );

    assign retire_tag          = retire_rec.tag;
    assign retire_pc           = retire_rec.pc;
    assign retire_fetch_cycle  = retire_rec.fetch_cycle;
    assign retire_stall_cycles = retire_rec.stall_cycles;
    assign retire_cycle        = retire_rec.retire_cycle;
    assign retire_result       = retire_rec.result;

endmodule

// ==== pipeline_tracker.sv ====
`timescale 1ns/1ps

module pipeline_tracker (
    input  logic                  clk,
    input  logic                  rst,
    stage_if.mon                  fetch_mon,
    input  logic                  in_accept,
    input  pipe_pkg::tag_t        in_tag,
    input  logic                  ret_valid,
    input  pipe_pkg::tag_t        ret_tag,
    input  pipe_pkg::word_t       ret_result,
    output logic                  retire_valid,
    output pipe_pkg::retire_rec_t retire_rec
);

    pipe_pkg::cyc_t  cycle;
    pipe_pkg::cyc_t  fetch_tab [pipe_pkg::TAG_DEPTH];
    pipe_pkg::cyc_t  stall_tab [pipe_pkg::TAG_DEPTH];
    pipe_pkg::word_t pc_tab    [pipe_pkg::TAG_DEPTH];

    always_ff @(posedge clk) begin
        if (rst)
            cycle <= '0;
        else
            cycle <= cycle + 1'b1;
    end

    // Accept and hold never coincide, so the stall entries written here differ
    always_ff @(posedge clk) begin
        if (in_accept) begin
            fetch_tab[in_tag] <= cycle;
            stall_tab[in_tag] <= '0;
        end
        if (fetch_mon.valid && fetch_mon.hold)
            stall_tab[fetch_mon.tag] <= stall_tab[fetch_mon.tag] + 1'b1;
        // PC becomes visible one cycle after acceptance
        if (fetch_mon.valid)
            pc_tab[fetch_mon.tag] <= fetch_mon.payload.pc;
    end

    always_ff @(posedge clk) begin
        if (rst)
            retire_valid <= 1'b0;
        else
            retire_valid <= ret_valid;
    end

    always_ff @(posedge clk) begin
        if (ret_valid) begin
            retire_rec <= '{tag:          ret_tag,
                            pc:           pc_tab[ret_tag],
                            fetch_cycle:  fetch_tab[ret_tag],
                            stall_cycles: stall_tab[ret_tag],
                            retire_cycle: cycle,
                            result:       ret_result};
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module pipe_tb -f list.f -o Vpipe_tb

status=0
./obj_dir/Vpipe_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi
echo "Simulation passed"

// ==== stage_if.sv ====
`timescale 1ns/1ps

interface stage_if #(
    parameter type payload_t = logic
) ();

    logic            valid;
    pipe_pkg::tag_t  tag;
    payload_t        payload;
    // Raised by the receiving stage to freeze the sender's register
    logic            hold;

    modport src (
        output valid,
        output tag,
        output payload,
        input  hold
    );

    modport dst (
        input  valid,
        input  tag,
        input  payload,
        output hold
    );

    // Observer view for hazard checks and the tracker
    modport mon (
        input valid,
        input tag,
        input payload,
        input hold
    );

endinterface

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule
